//--- pcs_rx_pkg.sv
`default_nettype none

package pcs_rx_pkg;

        // Sync header values of a 66b block
        localparam logic [1:0] SYNC_DATA = 2'b01;       // Eight data octets follow
        localparam logic [1:0] SYNC_CTRL = 2'b10;       // Block type byte leads payload

        // Block type field of control blocks
        localparam logic [7:0] BT_IDLE  = 8'h1E;        // All control characters
        localparam logic [7:0] BT_START = 8'h78;        // Start in lane 0

        // Terminate types, T0 through T7
        localparam int N_TERM_TYPES = 8;
        localparam logic [N_TERM_TYPES-1:0][7:0] BT_TERM_LIST = {
                8'h87,
                8'h99,
                8'hAA,
                8'hB4,
                8'hCC,
                8'hD2,
                8'hE1,
                8'hFF
        };

        // Control view of the payload word
        typedef struct packed {
                logic [7:0]  block_type;        // First octet after sync header
                logic [55:0] ctrl_body;         // Control characters / data octets
        } ctrl_view_t;

        // Same 64-bit payload, data or control interpretation
        typedef union packed {
                logic [7:0][7:0] data_bytes;    // Data block octets
                ctrl_view_t      ctrl;          // Control block fields
        } blk_payload_u;

        // One received block plus the marker flag from the aligner
        typedef struct packed {
                logic [1:0]   sync_hdr;
                blk_payload_u payload;
                logic         sol_tag;          // Set on alignment markers
        } rx_block_t;

        // Class of a block as seen by the receive state machine
        typedef enum logic [2:0] {
                BLK_DATA  = 3'd0,
                BLK_IDLE  = 3'd1,
                BLK_START = 3'd2,
                BLK_TERM  = 3'd3,
                BLK_OCTRL = 3'd4,
                BLK_ERR   = 3'd5
        } blk_class_e;

        // Idle used to repay dropped markers
        localparam rx_block_t PCS_IDLE_BLOCK = rx_block_t'({
                SYNC_CTRL,
                BT_IDLE,
                56'h0,
                1'b0
        });

endpackage

`default_nettype wire

//--- am_marker_tracker.sv
`default_nettype none

module am_marker_tracker
        import pcs_rx_pkg::*;
#(
        parameter int MAX_DEBT = 20             // One idle owed per lane marker
)
(
        input  wire             i_clock,
        input  wire             i_rst_n,
        input  wire             i_in_valid,
        input  wire rx_block_t  i_in_block,
        input  wire             i_fifo_full,
        input  wire             i_idle_paid,
        output logic            o_in_ready,
        output logic            o_wr_en,
        output rx_block_t       o_wr_block,
        output logic            o_debt_pending
);

        localparam int DEBT_W = $clog2(MAX_DEBT + 1);          // Holds 0..MAX_DEBT
        localparam logic [DEBT_W-1:0] DEBT_CAP = DEBT_W'(MAX_DEBT);

        logic              accept;             // Upstream handshake
        logic              marker_in;          // Accepted block is a marker
        logic [DEBT_W-1:0] debt_q;             // Idles still owed

        // Room in the FIFO is the only thing that stalls upstream
        assign o_in_ready = ~i_fifo_full;
        assign accept     = i_in_valid & o_in_ready;

        // Markers are swallowed here, everything else goes to the FIFO
        assign marker_in  = accept & i_in_block.sol_tag;
        assign o_wr_en    = accept & ~i_in_block.sol_tag;
        assign o_wr_block = i_in_block;         // Tag already clear on written blocks

        // Debt counter
        // Marker adds one, paid idle removes one, both at once cancel
        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        debt_q <= '0;
                end
                else
                begin
                        case ({marker_in, i_idle_paid})
                                2'b10:
                                begin
                                        if (debt_q != DEBT_CAP)        // Saturate
                                                debt_q <= debt_q + DEBT_W'(1);
                                end
                                2'b01:
                                begin
                                        if (debt_q != '0)               // Never wrap below zero
                                                debt_q <= debt_q - DEBT_W'(1);
                                end
                                default:
                                begin
                                        debt_q <= debt_q;       // Idle, or marker and pay together
                                end
                        endcase
                end
        end

        // Compensator only needs to know if anything is owed
        assign o_debt_pending = (debt_q != '0);

endmodule

`default_nettype wire

//--- block_classifier.sv
`default_nettype none

module block_classifier
        import pcs_rx_pkg::*;
(
        input  wire             i_clock,
        input  wire             i_rst_n,
        input  wire rx_block_t  i_head,
        input  wire             i_emit_valid,
        input  wire blk_class_e i_emit_class,
        input  wire             i_head_stall,   // Head block on output, not taken
        output blk_class_e      o_head_class,
        output logic            o_between_pkts
);

        logic       is_term;                    // Head type byte is a terminate
        logic [7:0] head_type;                  // Control view of the head
        logic       between_q;                  // Receiver outside a packet
        logic       hold_q;                     // Head was stalled last cycle

        assign head_type = i_head.payload.ctrl.block_type;

        // Match against the eight terminate encodings
        always_comb
        begin
                is_term = 1'b0;
                for (int i = 0; i < N_TERM_TYPES; i++)
                begin
                        if (head_type == BT_TERM_LIST[i])
                                is_term = 1'b1;
                end
        end

        // Head classification, header first then type byte
        always_comb
        begin
                case (i_head.sync_hdr)
                        SYNC_DATA:
                        begin
                                o_head_class = BLK_DATA;
                        end
                        SYNC_CTRL:
                        begin
                                if (head_type == BT_IDLE)
                                        o_head_class = BLK_IDLE;
                                else if (head_type == BT_START)
                                        o_head_class = BLK_START;
                                else if (is_term)
                                        o_head_class = BLK_TERM;
                                else
                                        o_head_class = BLK_OCTRL;  // Ordered sets and the rest
                        end
                        default:
                        begin
                                o_head_class = BLK_ERR;         // 00 and 11 are invalid
                        end
                endcase
        end

        // Packet state, follows what actually left the output
        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        between_q <= 1'b1;              // Start between packets
                        hold_q    <= 1'b0;
                end
                else
                begin
                        hold_q <= i_head_stall;
                        if (i_emit_valid)
                        begin
                                case (i_emit_class)
                                        BLK_IDLE, BLK_TERM, BLK_OCTRL:
                                                between_q <= 1'b1;
                                        BLK_START, BLK_DATA:
                                                between_q <= 1'b0;
                                        default:
                                                between_q <= between_q; // ERR keeps state
                                endcase
                        end
                end
        end

        // No insertion may displace a head block already on the output
        assign o_between_pkts = between_q & ~hold_q;

endmodule

`default_nettype wire

//--- sync_fifo.sv
`default_nettype none

module sync_fifo
        import pcs_rx_pkg::*;
#(
        parameter int FIFO_DEPTH = 16           // Power of two
)
(
        input  wire             i_clock,
        input  wire             i_rst_n,
        input  wire             i_wr_en,
        input  wire rx_block_t  i_wr_block,
        input  wire             i_rd_en,
        output rx_block_t       o_head,
        output logic            o_full,
        output logic            o_empty
);

        localparam int ADDR_W = $clog2(FIFO_DEPTH);

        rx_block_t       mem [FIFO_DEPTH];      // Block storage
        logic [ADDR_W:0] wr_ptr_q;              // Extra MSB tells full from empty
        logic [ADDR_W:0] rd_ptr_q;
        logic            do_wr;
        logic            do_rd;

        // Flags from pointer compare
        assign o_empty = (wr_ptr_q == rd_ptr_q);
        assign o_full  = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                         (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);

        // Overflow and underflow requests are dropped
        assign do_wr = i_wr_en & ~o_full;
        assign do_rd = i_rd_en & ~o_empty;

        // First-word fall-through view of the oldest entry
        assign o_head = mem[rd_ptr_q[ADDR_W-1:0]];

        always_ff @(posedge i_clock)
        begin
                if (do_wr)
                        mem[wr_ptr_q[ADDR_W-1:0]] <= i_wr_block;
        end

        // Pointers
        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        wr_ptr_q <= '0;
                        rd_ptr_q <= '0;
                end
                else
                begin
                        if (do_wr)
                                wr_ptr_q <= wr_ptr_q + (ADDR_W + 1)'(1);
                        if (do_rd)
                                rd_ptr_q <= rd_ptr_q + (ADDR_W + 1)'(1);
                end
        end

endmodule

`default_nettype wire

//--- clock_comp_rx.sv
`default_nettype none

module clock_comp_rx
        import pcs_rx_pkg::*;
(
        input  wire             i_debt_pending,
        input  wire             i_between_pkts,
        input  wire rx_block_t  i_head,
        input  wire blk_class_e i_head_class,
        input  wire             i_fifo_empty,
        input  wire             i_out_ready,
        output logic            o_out_valid,
        output rx_block_t       o_out_block,
        output logic            o_rd_en,
        output logic            o_idle_paid,
        output logic            o_emit_valid,
        output blk_class_e      o_emit_class,
        output logic            o_head_stall
);

        logic insert;                           // Present an idle this cycle
        logic handshake;                        // Output block taken

        // Idles go in only while the receiver waits for control blocks,
        // so the downstream decoder never sees one inside a packet
        assign insert = i_debt_pending & i_between_pkts;

        // Something to offer if owed or buffered
        assign o_out_valid = insert | ~i_fifo_empty;

        always_comb
        begin
                if (insert)
                        o_out_block = PCS_IDLE_BLOCK;
                else
                        o_out_block = i_head;
                o_out_block.sol_tag = 1'b0;     // Never tagged downstream
        end

        assign handshake = o_out_valid & i_out_ready;

        // Exactly one source is consumed per handshake
        assign o_idle_paid = handshake & insert;        // Repay one idle
        assign o_rd_en     = handshake & ~insert;       // Pop the FIFO

        // Report to the classifier what went out
        assign o_emit_valid = handshake;
        assign o_emit_class = insert ? BLK_IDLE : i_head_class;

        // Head waiting on the output, keeps later debt from replacing it
        assign o_head_stall = o_out_valid & ~i_out_ready & ~insert;

endmodule

`default_nettype wire

//--- pcs_rx_clock_comp_top.sv
`default_nettype none

module pcs_rx_clock_comp_top
        import pcs_rx_pkg::*;
#(
        parameter int FIFO_DEPTH = 16,          // Blocks of elasticity
        parameter int MAX_DEBT   = 20           // Number of lanes
)
(
        input  wire             i_clock,
        input  wire             i_rst_n,
        input  wire             i_in_valid,
        input  wire rx_block_t  i_in_block,
        output logic            o_in_ready,
        output logic            o_out_valid,
        output rx_block_t       o_out_block,
        input  wire             i_out_ready
);

        logic       fifo_full;
        logic       fifo_empty;
        logic       wr_en;
        rx_block_t  wr_block;
        logic       rd_en;
        rx_block_t  head;                       // Oldest buffered block
        blk_class_e head_class;
        logic       between_pkts;
        logic       debt_pending;
        logic       idle_paid;
        logic       emit_valid;
        blk_class_e emit_class;
        logic       head_stall;

        am_marker_tracker #(.MAX_DEBT(MAX_DEBT)) am_marker_tracker_inst (
                .i_clock        (i_clock),
                .i_rst_n        (i_rst_n),
                .i_in_valid     (i_in_valid),
                .i_in_block     (i_in_block),
                .i_fifo_full    (fifo_full),
                .i_idle_paid    (idle_paid),
                .o_in_ready     (o_in_ready),
                .o_wr_en        (wr_en),
                .o_wr_block     (wr_block),
                .o_debt_pending (debt_pending)
        );

        sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) sync_fifo_inst (
                .i_clock        (i_clock),
                .i_rst_n        (i_rst_n),
                .i_wr_en        (wr_en),
                .i_wr_block     (wr_block),
                .i_rd_en        (rd_en),
                .o_head         (head),
                .o_full         (fifo_full),
                .o_empty        (fifo_empty)
        );

        block_classifier block_classifier_inst (
                .i_clock        (i_clock),
                .i_rst_n        (i_rst_n),
                .i_head         (head),
                .i_emit_valid   (emit_valid),
                .i_emit_class   (emit_class),
                .i_head_stall   (head_stall),
                .o_head_class   (head_class),
                .o_between_pkts (between_pkts)
        );

        clock_comp_rx clock_comp_rx_inst (
                .i_debt_pending (debt_pending),
                .i_between_pkts (between_pkts),
                .i_head         (head),
                .i_head_class   (head_class),
                .i_fifo_empty   (fifo_empty),
                .i_out_ready    (i_out_ready),
                .o_out_valid    (o_out_valid),
                .o_out_block    (o_out_block),
                .o_rd_en        (rd_en),
                .o_idle_paid    (idle_paid),
                .o_emit_valid   (emit_valid),
                .o_emit_class   (emit_class),
                .o_head_stall   (head_stall)
        );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen
#(
        parameter real PERIOD_NS    = 8.0,      // Clock period
        parameter int  RESET_CYCLES = 8         // Rising edges held in reset
)
(
        output logic o_clock,
        output logic o_rst_n
);
        timeunit 1ns;
        timeprecision 100ps;

        initial
        begin
                o_clock = 1'b0;
                forever #(PERIOD_NS / 2.0) o_clock = ~o_clock;
        end

        // Release just after an edge, like the other stimulus
        initial
        begin
                o_rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge o_clock);
                #1;
                o_rst_n = 1'b1;
        end

endmodule

`default_nettype wire

//--- tb_pcs_rx_clock_comp.sv
`default_nettype none

module tb_pcs_rx_clock_comp
        import pcs_rx_pkg::*;
();
        timeunit 1ns;
        timeprecision 100ps;

        localparam int FIFO_DEPTH = 16;
        localparam int MAX_DEBT   = 20;
        localparam int N_PKTS     = 60;         // Packets in the run
        localparam rx_block_t INS_IDLE = {2'b10, 8'h1E, 56'h0, 1'b0};  // Zero-content idle
        localparam logic [7:0] TERM_TYPES [8] = '{8'h87, 8'h99, 8'hAA, 8'hB4,
                                                  8'hCC, 8'hD2, 8'hE1, 8'hFF};

        logic       clock;
        logic       rst_n;
        logic       in_valid;
        rx_block_t  in_block;
        logic       in_ready;
        logic       out_valid;
        rx_block_t  out_block;
        logic       out_ready;

        int         seed = 32'h0b2a_fcd4;
        int         ready_level;                // Chance of out_ready in quarters
        rx_block_t  stim_q [$];                 // Full upstream stream with markers
        rx_block_t  exp_q [$];                  // Buffered blocks still owed downstream
        int         debt_model = 0;             // Idles owed for dropped markers
        int         owed_total = 0;
        int         markers_in = 0;
        int         idles_in = 0;
        int         idles_out = 0;
        bit         between_model = 1'b1;       // Receiver outside a packet
        bit         stall_seen = 1'b0;
        rx_block_t  stall_block;
        int         err_value = 0;
        int         err_proto = 0;
        int         cycles = 0;
        int         cycle_limit = 0;

        tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(8)) tb_clock_gen_inst (
                .o_clock        (clock),
                .o_rst_n        (rst_n)
        );

        pcs_rx_clock_comp_top #(.FIFO_DEPTH(FIFO_DEPTH), .MAX_DEBT(MAX_DEBT))
        pcs_rx_clock_comp_top_inst (
                .i_clock        (clock),
                .i_rst_n        (rst_n),
                .i_in_valid     (in_valid),
                .i_in_block     (in_block),
                .o_in_ready     (in_ready),
                .o_out_valid    (out_valid),
                .o_out_block    (out_block),
                .i_out_ready    (out_ready)
        );

        // Header first then the control type byte
        function automatic blk_class_e classify_block(input rx_block_t blk);
                logic [7:0] bt;
                bt = blk.payload.ctrl.block_type;
                if (blk.sync_hdr == 2'b01)
                        return BLK_DATA;
                if (blk.sync_hdr != 2'b10)
                        return BLK_ERR;
                if (bt == 8'h1E)
                        return BLK_IDLE;
                if (bt == 8'h78)
                        return BLK_START;
                foreach (TERM_TYPES[i])
                        if (bt == TERM_TYPES[i])
                                return BLK_TERM;
                return BLK_OCTRL;
        endfunction

        function automatic rx_block_t make_ctrl(input logic [7:0] bt, input logic [55:0] body);
                return {2'b10, bt, body, 1'b0};
        endfunction

        task automatic fail_value(input string name, input logic [66:0] got,
                                  input logic [66:0] exp);
                err_value++;
                $display("FAIL t=%0t %s: got %0h expected %0h", $time, name, got, exp);
        endtask

        task automatic fail_proto(input string msg);
                err_proto++;
                $display("Error at %0t: %s", $time, msg);
        endtask

        task automatic report_and_finish(input bit timed_out);
                $display("Errors: value %0d, protocol %0d, timeout %0d",
                         err_value, err_proto, int'(timed_out));
                if (!timed_out && err_value == 0 && err_proto == 0)
                        $display("Everything OK");
                else
                        $display("Something failed");
                $finish;
        endtask

        // Random marker after roughly one block in six
        task automatic push_with_marker(input rx_block_t blk);
                stim_q.push_back(blk);
                if ($unsigned($random(seed)) % 6 == 0)
                        stim_q.push_back({2'b10, $random(seed), $random(seed), 1'b1});
        endtask

        task automatic build_traffic();
                int         n;
                int         gap_seq;
                logic [2:0] pick;
                gap_seq = 1;                    // Numbered gap idles never have zero content
                for (int p = 0; p <= N_PKTS; p++)
                begin
                        n = 1 + int'($unsigned($random(seed)) % 4);
                        repeat (n)
                        begin
                                push_with_marker(make_ctrl(8'h1E, 56'(gap_seq)));
                                gap_seq++;
                        end
                        if (p == N_PKTS)
                                break;          // Trailing gap only
                        push_with_marker(make_ctrl(8'h78, {$random(seed), 24'h0}));
                        n = 1 + int'($unsigned($random(seed)) % 8);
                        repeat (n)
                                push_with_marker({2'b01, $random(seed), $random(seed), 1'b0});
                        pick = 3'($random(seed));
                        push_with_marker(make_ctrl(TERM_TYPES[pick], 56'h0));
                end
        endtask

        // Next edge plus 1 ns with a fresh out_ready draw
        task automatic next_cycle();
                @(posedge clock);
                #1;
                out_ready = ($unsigned($random(seed)) % 4) < ready_level;
        endtask

        task automatic send_block(input rx_block_t blk);
                bit taken;
                taken    = 1'b0;
                in_valid = 1'b1;
                in_block = blk;
                while (!taken)
                begin
                        @(negedge clock);
                        taken = in_ready;       // Accepted at the coming edge
                        next_cycle();
                end
                in_valid = 1'b0;
        endtask

        task automatic check_quiet();
                assert (!out_valid) else fail_value("o_out_valid", 67'(out_valid), 67'(0));
                assert (in_ready) else fail_value("o_in_ready", 67'(in_ready), 67'(1));
        endtask

        task automatic take_output(input rx_block_t blk);
                blk_class_e cls;
                cls = classify_block(blk);
                if (cls == BLK_IDLE)
                        idles_out++;
                if (blk == INS_IDLE)
                begin
                        assert (debt_model > 0) else fail_proto("idle inserted with no debt owed");
                        assert (between_model) else fail_proto("idle inserted inside a packet");
                        if (debt_model > 0)
                                debt_model--;
                end
                else if (exp_q.size() == 0)
                        fail_proto("block sent while nothing was buffered");
                else
                begin
                        assert (blk == exp_q[0]) else fail_value("o_out_block", blk, exp_q[0]);
                        void'(exp_q.pop_front());
                end
                case (cls)
                        BLK_IDLE, BLK_TERM, BLK_OCTRL:  between_model = 1'b1;
                        BLK_START, BLK_DATA:            between_model = 1'b0;
                        default:                        ;       // ERR keeps state
                endcase
        endtask

        task automatic accept_input(input rx_block_t blk);
                if (blk.sol_tag)
                begin
                        markers_in++;
                        if (debt_model < MAX_DEBT)      // Saturating debt
                        begin
                                debt_model++;
                                owed_total++;
                        end
                end
                else
                begin
                        exp_q.push_back(blk);
                        if (classify_block(blk) == BLK_IDLE)
                                idles_in++;
                end
        endtask

        // Markers never reach the output
        assert property (@(posedge clock) disable iff (!rst_n) out_valid |-> !out_block.sol_tag)
        else fail_proto("tagged marker block on the output");

        // Mid-cycle monitor sees what the next edge will take
        always @(negedge clock)
        begin
                if (!rst_n)
                        stall_seen = 1'b0;
                else
                begin
                        assert (in_ready == (exp_q.size() < FIFO_DEPTH))
                        else fail_value("o_in_ready", 67'(in_ready),
                                        67'(exp_q.size() < FIFO_DEPTH));
                        if (stall_seen)         // Held since last cycle
                        begin
                                assert (out_valid)
                                else fail_value("o_out_valid", 67'(out_valid), 67'(1));
                                assert (out_block == stall_block)
                                else fail_value("o_out_block", out_block, stall_block);
                        end
                        stall_seen  = out_valid && !out_ready;
                        stall_block = out_block;
                        if (out_valid && out_ready)
                                take_output(out_block);        // Pop before push
                        if (in_valid && in_ready)
                                accept_input(in_block);
                end
        end

        always @(posedge clock)
        begin
                cycles++;
                if (cycle_limit > 0 && cycles >= cycle_limit)
                begin
                        $display("Timeout: run still busy after %0d cycles", cycles);
                        report_and_finish(1'b1);
                end
        end

        initial
        begin
                in_valid    = 1'b0;
                in_block    = '0;
                out_ready   = 1'b0;
                ready_level = 1;                // Heavy back-pressure first
                build_traffic();
                cycle_limit = 40 * stim_q.size();
                @(negedge clock);
                while (!rst_n)
                begin
                        check_quiet();
                        @(negedge clock);
                end
                check_quiet();                  // First cycle out of reset
                next_cycle();
                foreach (stim_q[i])
                begin
                        if (i == stim_q.size() / 2)
                                ready_level = 3;
                        if ($unsigned($random(seed)) % 8 == 0)
                                next_cycle();   // Upstream bubble
                        send_block(stim_q[i]);
                end
                // Drain the buffer, then wait for the DUT to stop offering idles
                while (exp_q.size() != 0 || out_valid)
                        next_cycle();
                @(negedge clock);
                assert (idles_out - idles_in == owed_total)
                else fail_value("repaid idles", 67'(idles_out - idles_in), 67'(owed_total));
                $display("Sent %0d blocks, %0d markers, %0d idles repaid",
                         stim_q.size(), markers_in, idles_out - idles_in);
                report_and_finish(1'b0);
        end

endmodule

`default_nettype wire

//--- compile.f
pcs_rx_pkg.sv
am_marker_tracker.sv
block_classifier.sv
sync_fifo.sv
clock_comp_rx.sv
pcs_rx_clock_comp_top.sv
tb_clock_gen.sv
tb_pcs_rx_clock_comp.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_pcs_rx_clock_comp
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Everything OK$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
